// File: sf_cases.txt
# compress wsf block_type mixed scfsi, then 36 hex scalefactors (field 0 first), then flags
# flags bit 0 adds random bit gaps, bit 1 restarts from a half-parsed frame first
f 0 0 0 0 0123456789abcdeffedcba98765432105a5a 0
9 0 0 0 0 9e37a1c4b82d6f05c3e8147ad29b6e0f3a71 0
d 0 0 0 0 c5d2e8f1a7b3946e0d8c2b5f7a1e39d46c8b 0
e 0 0 0 0 123456789abcdef0123456789abcdef01234 0
5 0 0 0 0 edcba98765432100fedcba9876543210fedc 0
b 0 0 0 0 8f4b2e6a1d9c5073be81f4a62d7c09e53b18 0
0 0 0 0 0 0123456789abcdeffedcba98765432105a5a 0
4 0 0 0 0 9e37a1c4b82d6f05c3e8147ad29b6e0f3a71 0
1 0 0 0 0 c5d2e8f1a7b3946e0d8c2b5f7a1e39d46c8b 0
f 0 0 0 5 aaaa5555aaaa5555aaaa5555aaaa5555aaaa 0
f 0 0 0 f 0123456789abcdeffedcba98765432105a5a 0
a 0 0 0 a 9e37a1c4b82d6f05c3e8147ad29b6e0f3a71 0
7 0 0 0 3 c5d2e8f1a7b3946e0d8c2b5f7a1e39d46c8b 0
c 0 0 0 8 123456789abcdef0123456789abcdef01234 0
f 1 1 0 0 edcba98765432100fedcba9876543210fedc 0
f 0 2 0 0 8f4b2e6a1d9c5073be81f4a62d7c09e53b18 0
f 1 2 0 0 0123456789abcdeffedcba98765432105a5a 0
9 1 2 1 0 9e37a1c4b82d6f05c3e8147ad29b6e0f3a71 0
4 1 2 0 0 c5d2e8f1a7b3946e0d8c2b5f7a1e39d46c8b 0
0 1 2 0 0 123456789abcdef0123456789abcdef01234 0
e 1 2 0 f edcba98765432100fedcba9876543210fedc 0
6 1 3 0 0 8f4b2e6a1d9c5073be81f4a62d7c09e53b18 0
f 0 0 0 0 0123456789abcdeffedcba98765432105a5a 1
f 1 2 0 0 0123456789abcdeffedcba98765432105a5a 1
f 0 0 0 5 aaaa5555aaaa5555aaaa5555aaaa5555aaaa 1
d 0 0 0 0 c5d2e8f1a7b3946e0d8c2b5f7a1e39d46c8b 2
9 1 2 1 0 9e37a1c4b82d6f05c3e8147ad29b6e0f3a71 3
2 0 0 0 6 ffffffffffffffffffffffffffffffffffff 0
8 1 2 0 0 aaaa5555aaaa5555aaaa5555aaaa5555aaaa 1
3 0 0 0 0 edcba98765432100fedcba9876543210fedc 2

// File: files.f
sf_pkg.sv
sf_slen_decode.sv
sf_bit_collector.sv
sf_parse_ctrl.sv
sf_band_store.sv
sf_parser_top.sv
sf_parser_assert.sv
tb_sf_parser.sv

// File: Makefile
# Verilator build and run for the scalefactor parser testbench

GR        ?= 1
TOP       ?= tb_sf_parser
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GGR=$(GR) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_sf_parser.sv
`timescale 1ns/100ps

module tb_sf_parser #(
  parameter int GR = 1
);

  import sf_pkg::*;

  localparam int CASE_CYCLES = 600;
  localparam int DONE_LIMIT  = 64;
  localparam int SLEN1_TAB [16] = '{0, 0, 0, 0, 3, 1, 1, 1, 2, 2, 2, 3, 3, 3, 4, 4};
  localparam int SLEN2_TAB [16] = '{0, 1, 2, 3, 0, 1, 2, 3, 1, 2, 3, 1, 2, 3, 2, 3};
  localparam side_info_t PRELUDE_SI = side_info_t'(12'hf00); // Long block, widest fields

  logic       clk = 1'b0;
  logic       rst;
  logic       side_info_valid;
  side_info_t side_info;
  logic       bit_valid;
  logic       bit_data;
  sf_long_t   scalefac_l;
  sf_short_t  scalefac_s;
  logic       done;

  side_info_t   case_si    [$];
  logic [143:0] case_vals  [$];
  logic [1:0]   case_flags [$];
  bit           stream     [$]; // Serial bits of the current case
  int           num_cases  = 0;
  int           cur_case   = -1;
  int           mismatches = 0;
  int           failures   = 0;
  int           done_seen  = 0;
  int           seed;

  sf_parser_top #(
    .GR (GR)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .side_info_valid (side_info_valid),
    .side_info       (side_info),
    .bit_valid       (bit_valid),
    .bit_data        (bit_data),
    .scalefac_l      (scalefac_l),
    .scalefac_s      (scalefac_s),
    .done            (done)
  );

  always #4 clk = ~clk;

  // Every done pulse, wanted or not
  always @(negedge clk) begin
    if (done) begin
      done_seen++;
    end
  end

  task automatic check_long(input sf_long_t got, input sf_long_t exp, input string name);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t case %0d %s got=%h exp=%h", $time, cur_case, name, got, exp);
    end
  endtask

  task automatic check_short(input sf_short_t got, input sf_short_t exp, input string name);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t case %0d %s got=%h exp=%h", $time, cur_case, name, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      mismatches++;
      $display("MISMATCH t=%0t case %0d %s got=%0d exp=%0d", $time, cur_case, name, got, exp);
    end
  endtask

  // Expected arrays and serial stream from the band and region rules
  task automatic build_case(input side_info_t si, input logic [143:0] vals,
                            output sf_long_t exp_l, output sf_short_t exp_s);
    bit        is_short;
    bit        second;
    bit        reused;
    int        region;
    int        width;
    int        nfields;
    sf_value_t v;
    stream.delete();
    exp_l    = '0;
    exp_s    = '0;
    is_short = si.window_switching_flag && (si.block_type == 2'd2);
    nfields  = is_short ? NUM_SHORT_FIELDS : NUM_LONG_BANDS;
    for (int f = 0; f < nfields; f++) begin
      if (is_short) begin
        second = (f >= NUM_SHORT_FIELDS / 2);
        reused = 1'b0;
      end else begin
        region = (f < 6) ? 0 : (f < 11) ? 1 : (f < 16) ? 2 : 3;
        second = (region >= 2);
        reused = (GR != 0) && si.scfsi[region];
      end
      width = second ? SLEN2_TAB[si.scalefac_compress] : SLEN1_TAB[si.scalefac_compress];
      if (reused) begin
        width = 0;
      end
      v = sf_value_t'(vals[143 - 4 * f -: 4]) & sf_value_t'((1 << width) - 1);
      if (is_short) begin
        exp_s[f / 3][f % 3] = v;
      end else begin
        exp_l[f] = v;
      end
      for (int b = width - 1; b >= 0; b--) begin
        stream.push_back(v[b]); // MSB first
      end
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic data);
    @(posedge clk);
    side_info_valid <= 1'b0;
    bit_valid       <= valid;
    bit_data        <= data;
  endtask

  task automatic start_frame(input side_info_t si, input logic stray_bit);
    @(posedge clk);
    side_info_valid <= 1'b1;
    side_info       <= si;
    bit_valid       <= stray_bit; // Not taken on the strobe cycle
    bit_data        <= 1'b1;
  endtask

  task automatic send_stream(input bit gaps);
    int idle;
    foreach (stream[i]) begin
      idle = gaps ? int'($random(seed) & 32'h3) : 0;
      repeat (idle) drive_cycle(1'b0, 1'b0);
      drive_cycle(1'b1, stream[i]);
    end
    drive_cycle(1'b0, 1'b0);
  endtask

  // Number of the negedge that saw done, 0 when it never came
  task automatic wait_done(output int cycles);
    cycles = 0;
    for (int n = 1; n <= DONE_LIMIT && cycles == 0; n++) begin
      @(negedge clk);
      if (done) begin
        cycles = n;
      end
    end
  endtask

  task automatic run_case(input int idx);
    sf_long_t  exp_l;
    sf_short_t exp_s;
    int        pulses_before;
    int        latency;
    cur_case = idx;
    build_case(case_si[idx], case_vals[idx], exp_l, exp_s);
    @(posedge clk);
    pulses_before = done_seen;
    if (case_flags[idx][1]) begin
      // Half-parsed frame that the real strobe cuts short
      start_frame(PRELUDE_SI, 1'b0);
      repeat (30) drive_cycle(1'b1, 1'($random(seed)));
      start_frame(case_si[idx], 1'b1);
    end else begin
      start_frame(case_si[idx], 1'b0);
    end
    send_stream(case_flags[idx][0]);
    wait_done(latency);
    if (latency == 0) begin
      failures++;
      $display("Case %0d: done did not arrive within %0d cycles of the last bit",
               idx, DONE_LIMIT);
    end else begin
      if (stream.size() == 0) begin
        check_count(latency, 1, "done latency");
      end
      check_long(scalefac_l, exp_l, "scalefac_l");
      check_short(scalefac_s, exp_s, "scalefac_s");
    end
    repeat (5) drive_cycle(1'b1, 1'($random(seed))); // Trailing bits of no frame
    repeat (3) drive_cycle(1'b0, 1'b0);
    @(negedge clk);
    check_long(scalefac_l, exp_l, "scalefac_l after trailing bits");
    check_short(scalefac_s, exp_s, "scalefac_s after trailing bits");
    @(posedge clk);
    check_count(done_seen - pulses_before, 1, "done pulses");
  endtask

  initial begin
    int           fd;
    int           n;
    string        line;
    logic [3:0]   comp;
    logic         ws;
    logic [1:0]   bt;
    logic         mixed;
    logic [3:0]   scfsi;
    logic [143:0] vals;
    logic [1:0]   flags;
    seed            = 32'h73b0;
    rst             = 1'b1;
    side_info_valid = 1'b0;
    side_info       = '0;
    bit_valid       = 1'b0;
    bit_data        = 1'b0;
    fd = $fopen("sf_cases.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("Could not open sf_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", comp, ws, bt, mixed, scfsi, vals, flags);
          if (n == 7) begin
            case_si.push_back(side_info_t'({comp, ws, bt, mixed, scfsi}));
            case_vals.push_back(vals);
            case_flags.push_back(flags);
          end
        end
      end
      $fclose(fd);
      num_cases = case_si.size();
      if (num_cases == 0) begin
        failures++;
        $display("No test cases found in sf_cases.txt");
      end
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // Bits before any frame must be ignored
    repeat (6) drive_cycle(1'b1, 1'b1);
    drive_cycle(1'b0, 1'b0);
    @(negedge clk);
    check_long(scalefac_l, '0, "scalefac_l before first frame");
    check_short(scalefac_s, '0, "scalefac_s before first frame");
    @(posedge clk);
    check_count(done_seen, 0, "done pulses before first frame");
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, u_dut.u_assert.assert_errors);
    if (mismatches + failures + u_dut.u_assert.assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog over the whole case list
  initial begin
    wait (num_cases > 0);
    repeat (num_cases * CASE_CYCLES) @(posedge clk);
    $display("Timeout: run exceeded %0d cycles", num_cases * CASE_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: sf_parser_assert.sv
`timescale 1ns/100ps

module sf_parser_assert (
  input logic              clk,
  input logic              rst,
  input logic              side_info_valid,
  input logic              done,
  input sf_pkg::sf_long_t  scalefac_l,
  input sf_pkg::sf_short_t scalefac_s
);

  int assert_errors = 0; // Failure tally, picked up by the testbench

  // One frame ends in a single done pulse
  done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      assert_errors++;
      $error("done high on two consecutive cycles");
    end

  done_low_after_reset: assert property (@(posedge clk) rst |=> !done)
    else begin
      assert_errors++;
      $error("done high in the cycle after reset");
    end

  // New frame starts from cleared arrays
  arrays_cleared: assert property (@(posedge clk) disable iff (rst)
      side_info_valid |=> (scalefac_l == '0 && scalefac_s == '0))
    else begin
      assert_errors++;
      $error("scalefactor arrays not zero after side_info_valid");
    end

endmodule

bind sf_parser_top sf_parser_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .side_info_valid (side_info_valid),
  .done            (done),
  .scalefac_l      (scalefac_l),
  .scalefac_s      (scalefac_s)
);

// File: sf_parser_top.sv
`timescale 1ns/100ps

module sf_parser_top #(
  parameter int GR = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               side_info_valid,
  input  sf_pkg::side_info_t side_info,
  input  logic               bit_valid,
  input  logic               bit_data,
  output sf_pkg::sf_long_t   scalefac_l,
  output sf_pkg::sf_short_t  scalefac_s,
  output logic               done
);

  import sf_pkg::*;

  side_info_t si_q;
  side_info_t si_frame;
  slen_t      slen1;
  slen_t      slen2;
  slen_t      field_width;
  logic       collect;
  logic       field_done;
  sf_value_t  field_value;
  logic       clear;
  logic       wr_en;
  sf_write_t  wr;

  always_ff @(posedge clk) begin
    if (side_info_valid) begin
      si_q <= side_info;
    end
  end

  // Fresh side info on the strobe cycle, held copy for the rest of the frame
  assign si_frame = side_info_valid ? side_info : si_q;

  sf_slen_decode u_slen (
    .scalefac_compress (si_frame.scalefac_compress),
    .slen1             (slen1),
    .slen2             (slen2)
  );

  sf_bit_collector u_collect (
    .clk         (clk),
    .rst         (rst),
    .collect     (collect),
    .field_width (field_width),
    .bit_valid   (bit_valid),
    .bit_data    (bit_data),
    .field_done  (field_done),
    .field_value (field_value)
  );

  sf_parse_ctrl #(
    .GR (GR)
  ) u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (side_info_valid),
    .side_info   (si_frame),
    .slen1       (slen1),
    .slen2       (slen2),
    .field_done  (field_done),
    .field_value (field_value),
    .collect     (collect),
    .field_width (field_width),
    .clear       (clear),
    .wr_en       (wr_en),
    .wr          (wr),
    .done        (done)
  );

  sf_band_store u_store (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .wr_en      (wr_en),
    .wr         (wr),
    .scalefac_l (scalefac_l),
    .scalefac_s (scalefac_s)
  );

endmodule

// File: sf_band_store.sv
`timescale 1ns/100ps

module sf_band_store (
  input  logic              clk,
  input  logic              rst,
  input  logic              clear,
  input  logic              wr_en,
  input  sf_pkg::sf_write_t wr,
  output sf_pkg::sf_long_t  scalefac_l,
  output sf_pkg::sf_short_t scalefac_s
);

  import sf_pkg::*;

  logic [3:0] band;
  logic [1:0] window;

  // Short fields run window fastest within a band
  assign band   = 4'(wr.index / NUM_WINDOWS);
  assign window = 2'(wr.index % NUM_WINDOWS);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      scalefac_l <= '0;
      scalefac_s <= '0;
    end else if (wr_en) begin
      if (wr.kind == BLOCK_LONG) begin
        if (wr.index < NUM_LONG_BANDS) begin
          scalefac_l[wr.index] <= wr.value;
        end
      end else if (band < NUM_SHORT_BANDS) begin
        scalefac_s[band][window] <= wr.value;
      end
    end
  end

endmodule

// File: sf_parse_ctrl.sv
`timescale 1ns/100ps

module sf_parse_ctrl #(
  parameter int GR = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  sf_pkg::side_info_t side_info,
  input  sf_pkg::slen_t      slen1,
  input  sf_pkg::slen_t      slen2,
  input  logic               field_done,
  input  sf_pkg::sf_value_t  field_value,
  output logic               collect,
  output sf_pkg::slen_t      field_width,
  output logic               clear,
  output logic               wr_en,
  output sf_pkg::sf_write_t  wr,
  output logic               done
);

  import sf_pkg::*;

  localparam logic [2:0] NO_REGION = 3'd4;
  localparam bit         REUSE     = (GR != 0); // Second granule honours scfsi

  ctrl_state_e state;
  logic [2:0]  region;
  field_idx_t  fidx;
  block_kind_e kind;

  slen_t       reg_width [4];
  field_idx_t  reg_first [4];
  field_idx_t  reg_last  [4];
  logic [3:0]  reg_live;

  logic [2:0]  search_from;
  logic [2:0]  next_region;
  slen_t       next_width;
  logic        last_field;

  // Mixed blocks fall through to the plain short layout
  assign kind = (side_info.window_switching_flag && side_info.block_type == 2'd2) ?
                BLOCK_SHORT : BLOCK_LONG;

  // Region map: long has four scfsi groups, short has two width halves
  always_comb begin
    if (kind == BLOCK_SHORT) begin
      reg_width = '{slen1, slen2, slen_t'(0), slen_t'(0)};
      reg_first = '{field_idx_t'(0), field_idx_t'(NUM_SHORT_FIELDS / 2),
                    field_idx_t'(0), field_idx_t'(0)};
      reg_last  = '{field_idx_t'(NUM_SHORT_FIELDS / 2 - 1), field_idx_t'(NUM_SHORT_FIELDS - 1),
                    field_idx_t'(0), field_idx_t'(0)};
    end else begin
      reg_width = '{slen1, slen1, slen2, slen2};
      reg_first = '{field_idx_t'(0), field_idx_t'(6), field_idx_t'(11), field_idx_t'(16)};
      reg_last  = '{field_idx_t'(5), field_idx_t'(10), field_idx_t'(15),
                    field_idx_t'(NUM_LONG_BANDS - 1)};
    end
    for (int r = 0; r < 4; r++) begin
      reg_live[r] = (reg_width[r] != '0) &&
                    !(REUSE && kind == BLOCK_LONG && side_info.scfsi[r]);
    end
  end

  // Next region that actually carries bits, searching upward
  assign search_from = (state == FIELD && !start) ? region + 3'd1 : 3'd0;

  always_comb begin
    next_region = NO_REGION;
    for (int r = 3; r >= 0; r--) begin
      if (r >= int'(search_from) && reg_live[r]) begin
        next_region = 3'(r);
      end
    end
  end

  assign next_width = (next_region == NO_REGION) ? slen_t'(0) : reg_width[next_region[1:0]];
  assign last_field = (fidx == reg_last[region[1:0]]);

  // Width must describe the field the next incoming bit belongs to
  always_comb begin
    case (state)
      SELECT:  field_width = next_width;
      FIELD:   field_width = (field_done && last_field) ? next_width : reg_width[region[1:0]];
      default: field_width = '0;
    endcase
  end

  assign collect = (state == SELECT || state == FIELD) && !start;
  assign clear   = start;
  assign wr_en   = (state == FIELD) && field_done && !start;
  assign wr      = '{kind: kind, index: fidx, value: field_value};
  assign done    = (state == DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      region <= '0;
      fidx   <= '0;
    end else if (start) begin
      region <= '0;
      fidx   <= '0;
      state  <= (next_region == NO_REGION) ? DONE : SELECT; // Empty frame finishes at once
    end else begin
      case (state)
        SELECT: begin
          region <= next_region;
          fidx   <= reg_first[next_region[1:0]];
          state  <= FIELD;
        end
        FIELD: begin
          if (field_done) begin
            if (!last_field) begin
              fidx <= fidx + field_idx_t'(1);
            end else if (next_region == NO_REGION) begin
              state <= DONE;
            end else begin
              region <= next_region; // Skipped regions leave their bands at zero
              fidx   <= reg_first[next_region[1:0]];
            end
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: sf_bit_collector.sv
`timescale 1ns/100ps

module sf_bit_collector (
  input  logic              clk,
  input  logic              rst,
  input  logic              collect,
  input  sf_pkg::slen_t     field_width,
  input  logic              bit_valid,
  input  logic              bit_data,
  output logic              field_done,
  output sf_pkg::sf_value_t field_value
);

  import sf_pkg::*;

  slen_t     bit_count;  // Bits of the current field taken so far
  slen_t     count_next;
  sf_value_t shift_q;

  // A bit arriving together with field_done is the first of the next field
  assign count_next = (field_done ? slen_t'(0) : bit_count) + slen_t'(1);

  always_ff @(posedge clk) begin
    if (rst || !collect) begin
      bit_count  <= '0;
      field_done <= 1'b0;
    end else if (bit_valid) begin
      bit_count  <= count_next;
      field_done <= (count_next == field_width);
    end else begin
      if (field_done) begin
        bit_count <= '0;
      end
      field_done <= 1'b0;
    end
  end

  // MSB first, so upper bits stay zero for narrow fields
  always_ff @(posedge clk) begin
    if (!collect || (field_done && !bit_valid)) begin
      shift_q <= '0;
    end else if (bit_valid) begin
      if (field_done) begin
        shift_q <= sf_value_t'(bit_data);
      end else begin
        shift_q <= {shift_q[SF_WIDTH-2:0], bit_data};
      end
    end
  end

  assign field_value = shift_q;

endmodule

// File: sf_slen_decode.sv
`timescale 1ns/100ps

module sf_slen_decode (
  input  logic [3:0]    scalefac_compress,
  output sf_pkg::slen_t slen1,
  output sf_pkg::slen_t slen2
);

  // Standard Layer III table, {slen1, slen2} per scalefac_compress
  always_comb begin
    case (scalefac_compress)
      4'd0: {slen1, slen2} = {3'd0, 3'd0};
      4'd1: {slen1, slen2} = {3'd0, 3'd1};
      4'd2: {slen1, slen2} = {3'd0, 3'd2};
      4'd3: {slen1, slen2} = {3'd0, 3'd3};
      4'd4: {slen1, slen2} = {3'd3, 3'd0}; // Only entry with slen1 set and slen2 zero
      4'd5: {slen1, slen2} = {3'd1, 3'd1};
      4'd6: {slen1, slen2} = {3'd1, 3'd2};
      4'd7: {slen1, slen2} = {3'd1, 3'd3};
      4'd8: {slen1, slen2} = {3'd2, 3'd1};
      4'd9: {slen1, slen2} = {3'd2, 3'd2};
      4'd10: {slen1, slen2} = {3'd2, 3'd3};
      4'd11: {slen1, slen2} = {3'd3, 3'd1};
      4'd12: {slen1, slen2} = {3'd3, 3'd2};
      4'd13: {slen1, slen2} = {3'd3, 3'd3};
      4'd14: {slen1, slen2} = {3'd4, 3'd2};
      default: {slen1, slen2} = {3'd4, 3'd3};
    endcase
  end

endmodule

// File: sf_pkg.sv
package sf_pkg;

  localparam int SF_WIDTH         = 4;
  localparam int NUM_LONG_BANDS   = 21;
  localparam int NUM_SHORT_BANDS  = 12;
  localparam int NUM_WINDOWS      = 3;
  localparam int NUM_SHORT_FIELDS = NUM_SHORT_BANDS * NUM_WINDOWS;

  typedef logic [SF_WIDTH-1:0] sf_value_t;
  typedef logic [2:0]          slen_t;      // Field width, 0 to 4 bits
  typedef logic [5:0]          field_idx_t; // Long band or short field index

  typedef sf_value_t [NUM_LONG_BANDS-1:0] sf_long_t;

  // Band major, window minor
  typedef sf_value_t [NUM_SHORT_BANDS-1:0][NUM_WINDOWS-1:0] sf_short_t;

  // Side-info fields of one granule and channel that steer the parse
  typedef struct packed {
    logic [3:0] scalefac_compress;
    logic       window_switching_flag;
    logic [1:0] block_type;
    logic       mixed_block_flag;
    logic [3:0] scfsi;         // Bit 0 covers bands 0-5
  } side_info_t;

  typedef enum logic {
    BLOCK_LONG,
    BLOCK_SHORT
  } block_kind_e;

  // One decoded field headed for the band store
  typedef struct packed {
    block_kind_e kind;
    field_idx_t  index;
    sf_value_t   value;
  } sf_write_t;

  typedef enum logic [1:0] {
    IDLE,
    SELECT,
    FIELD,
    DONE
  } ctrl_state_e;

endpackage
